/* logic/io_link_pkg.sv */
// io link definitions
// command codes of the menu controller link, shared buffer geometry
// and the core type byte returned during every command byte

package io_link_pkg;

	// configuration commands
	localparam logic [7:0] cmd_buttons    = 8'h01;
	localparam logic [7:0] cmd_joy0       = 8'h02;
	localparam logic [7:0] cmd_joy1       = 8'h03;
	localparam logic [7:0] cmd_status8    = 8'h15;
	localparam logic [7:0] cmd_mount      = 8'h1c;
	localparam logic [7:0] cmd_img_size   = 8'h1d;
	localparam logic [7:0] cmd_status32   = 8'h1e;

	// ps/2 keyboard bytes
	localparam logic [7:0] cmd_kbd        = 8'h05;

	// sd sector payload into the lower buffer half
	localparam logic [7:0] cmd_sector_wr  = 8'h17;

	// file download
	localparam logic [7:0] cmd_file_tx    = 8'h53;
	localparam logic [7:0] cmd_file_data  = 8'h54;
	localparam logic [7:0] cmd_file_index = 8'h55;

	// 8 bit core, shifted out on spi_do during byte 0
	localparam logic [7:0] core_type      = 8'ha4;

	// byte index within a frame, saturates at all ones
	localparam int byte_idx_w = 10;

	// sector region 0..511, file region 512..1023
	localparam int sector_bytes = 512;

endpackage

/* logic/spi_link.sv */
`timescale 1ns/1ns
// spi link receiver
// oversamples the SPI pins in clk_sys, assembles bytes MSB first,
// latches the command byte and shifts the core type out on spi_do

module spi_link (
	input  logic                               clk_sys,
	input  logic                               CONF_DATA0,
	input  logic                               spi_sck,
	input  logic                               spi_di,
	input  logic                               spi_sel,
	output logic                               spi_do,
	output logic [7:0]                         cmd,
	output logic                               byte_valid,
	output logic [7:0]                         byte_data,
	output logic [io_link_pkg::byte_idx_w-1:0] byte_idx,
	output logic                               frame_end
);
	import io_link_pkg::*;

	// two stage synchronizers
	logic [1:0]            sck_s;
	logic [1:0]            di_s;
	logic [1:0]            sel_s;
	logic                  sck_d;
	logic                  sel_d;
	logic                  sck_rise;
	logic                  sck_fall;
	logic [2:0]            bit_cnt;
	logic [6:0]            sbuf;
	logic [7:0]            rx_byte;
	// index of the byte being received, 0 is the command
	logic [byte_idx_w-1:0] idx;
	logic                  byte_done;

	always_ff @(posedge clk_sys or posedge CONF_DATA0) begin
		if (CONF_DATA0) begin
			sck_s <= '0;
			di_s  <= '0;
			sel_s <= '0;
			sck_d <= 1'b0;
			sel_d <= 1'b0;
		end else begin
			sck_s <= {sck_s[0], spi_sck};
			di_s  <= {di_s[0], spi_di};
			sel_s <= {sel_s[0], spi_sel};
			// previous synchronized samples for edge detect
			sck_d <= sck_s[1];
			sel_d <= sel_s[1];
		end
	end

	assign sck_rise  = sck_s[1] & ~sck_d;
	assign sck_fall  = ~sck_s[1] & sck_d;
	assign rx_byte   = {sbuf, di_s[1]};
	assign byte_done = sel_s[1] & sck_rise & (bit_cnt == 3'd7);

	// shift register and payload byte
	always_ff @(posedge clk_sys) begin
		if (sck_rise)
			sbuf <= rx_byte[6:0];
		if (byte_done && idx != '0)
			byte_data <= rx_byte;
	end

	always_ff @(posedge clk_sys or posedge CONF_DATA0) begin
		if (CONF_DATA0) begin
			bit_cnt    <= '0;
			idx        <= '0;
			cmd        <= '0;
			byte_valid <= 1'b0;
			byte_idx   <= '0;
			frame_end  <= 1'b0;
			spi_do     <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			frame_end  <= sel_d & ~sel_s[1];
			if (!sel_s[1]) begin
				// deselected, rearm for the next frame
				bit_cnt <= '0;
				idx     <= '0;
				cmd     <= '0;
				// first readback bit must be there before the first rising edge
				spi_do  <= core_type[7];
			end else begin
				if (sck_rise)
					bit_cnt <= bit_cnt + 3'd1;
				if (byte_done) begin
					if (idx == '0) begin
						cmd <= rx_byte;
					end else begin
						byte_valid <= 1'b1;
						byte_idx   <= idx;
					end
					// saturate on very long frames
					if (~&idx)
						idx <= idx + 1'b1;
				end
				// readback only during the command byte
				if (sck_fall)
					spi_do <= (idx == '0) ? core_type[~bit_cnt] : 1'b0;
			end
		end
	end

endmodule

/* logic/cmd_regs.sv */
`timescale 1ns/1ns
// configuration registers
// decodes buttons, joysticks, status, mount and image size commands
// into the registers and strobes seen by the core

module cmd_regs (
	input  logic                               clk_sys,
	input  logic                               CONF_DATA0,
	input  logic [7:0]                         cmd,
	input  logic                               byte_valid,
	input  logic [7:0]                         byte_data,
	input  logic [io_link_pkg::byte_idx_w-1:0] byte_idx,
	output logic [1:0]                         buttons,
	output logic [1:0]                         switches,
	output logic [7:0]                         joystick_0,
	output logic [7:0]                         joystick_1,
	output logic [31:0]                        status,
	output logic [1:0]                         img_mounted,
	output logic [32-1:0]                      img_size
);
	import io_link_pkg::*;

	logic       first_byte;
	logic       word_byte;
	// byte lane for 32 bit words, byte 1 is the low byte
	logic [1:0] lane;

	assign first_byte = (byte_idx == byte_idx_w'(1));
	assign word_byte  = (byte_idx >= byte_idx_w'(1)) && (byte_idx <= byte_idx_w'(4));
	assign lane       = byte_idx[1:0] - 2'd1;

	always_ff @(posedge clk_sys or posedge CONF_DATA0) begin
		if (CONF_DATA0) begin
			buttons     <= '0;
			switches    <= '0;
			joystick_0  <= '0;
			joystick_1  <= '0;
			status      <= '0;
			img_mounted <= '0;
			img_size    <= '0;
		end else begin
			// mount strobes last one cycle
			img_mounted <= '0;
			if (byte_valid) begin
				case (cmd)
					cmd_buttons: if (first_byte) begin
						buttons  <= byte_data[1:0];
						switches <= byte_data[3:2];
					end
					cmd_joy0: if (first_byte)
						joystick_0 <= byte_data;
					cmd_joy1: if (first_byte)
						joystick_1 <= byte_data;
					// legacy status, low byte only
					cmd_status8: if (first_byte)
						status[7:0] <= byte_data;
					cmd_status32: if (word_byte)
						status[{lane, 3'b000} +: 8] <= byte_data;
					// bit 0 selects the image slot
					cmd_mount: if (first_byte)
						img_mounted[byte_data[0]] <= 1'b1;
					cmd_img_size: if (word_byte)
						img_size[{lane, 3'b000} +: 8] <= byte_data;
					default: ;
				endcase
			end
		end
	end

	// the link never flags the command byte as payload
	a_no_payload_idx0: assert property (
		@(posedge clk_sys) disable iff (CONF_DATA0)
		byte_valid |-> (byte_idx != '0)
	);

endmodule

/* logic/ps2_kbd_tx.sv */
`timescale 1ns/1ns
// ps/2 keyboard emulation
// queues keyboard bytes in an 8 entry FIFO, sends them as ps/2 frames
// on a divided clock and decodes each keyboard frame into a key event

module ps2_kbd_tx #(
	parameter int PS2DIV = 100
) (
	input  logic        clk_sys,
	input  logic        CONF_DATA0,
	input  logic [7:0]  cmd,
	input  logic        byte_valid,
	input  logic [7:0]  byte_data,
	input  logic        frame_end,
	output logic        ps2_kbd_clk,
	output logic        ps2_kbd_data,
	output logic [10:0] ps2_key
);
	import io_link_pkg::*;

	localparam int div_w = $clog2(PS2DIV + 1);

	logic [7:0]       fifo [8];
	// extra pointer bit tells full from empty
	logic [3:0]       wptr;
	logic [3:0]       rptr;
	logic             fifo_full;
	logic             fifo_empty;
	logic             kbd_byte;
	logic             push;
	logic [div_w-1:0] div_cnt;
	logic             clk_ps2;
	logic             div_wrap;
	logic             ps2_rise;
	logic [3:0]       tx_state;
	logic [7:0]       tx_byte;
	logic             parity;
	logic [31:0]      key_raw;
	logic             got_key;
	logic             pressed;
	logic             extended;

	assign kbd_byte   = byte_valid && (cmd == cmd_kbd);
	assign fifo_full  = (wptr[2:0] == rptr[2:0]) && (wptr[3] != rptr[3]);
	assign fifo_empty = (wptr == rptr);
	assign push       = kbd_byte && !fifo_full;

	always_ff @(posedge clk_sys) begin
		if (push)
			fifo[wptr[2:0]] <= byte_data;
	end

	// half period of PS2DIV clk_sys cycles
	assign div_wrap = (div_cnt == div_w'(PS2DIV - 1));
	assign ps2_rise = div_wrap && !clk_ps2;

	// clock is held high while idle
	assign ps2_kbd_clk = clk_ps2 | (tx_state == 4'd0);

	always_ff @(posedge clk_sys or posedge CONF_DATA0) begin
		if (CONF_DATA0) begin
			wptr         <= '0;
			rptr         <= '0;
			div_cnt      <= '0;
			clk_ps2      <= 1'b0;
			tx_state     <= '0;
			tx_byte      <= '0;
			parity       <= 1'b0;
			ps2_kbd_data <= 1'b1;
		end else begin
			if (push)
				wptr <= wptr + 4'd1;
			if (div_wrap) begin
				div_cnt <= '0;
				clk_ps2 <= ~clk_ps2;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
			// data changes while the ps/2 clock is high
			if (ps2_rise) begin
				if (tx_state == 4'd0) begin
					if (!fifo_empty) begin
						tx_byte      <= fifo[rptr[2:0]];
						rptr         <= rptr + 4'd1;
						parity       <= 1'b1;
						tx_state     <= 4'd1;
						// start bit
						ps2_kbd_data <= 1'b0;
					end
				end else begin
					// data bits, LSB first
					if (tx_state <= 4'd8) begin
						ps2_kbd_data <= tx_byte[0];
						tx_byte      <= {1'b0, tx_byte[7:1]};
						parity       <= parity ^ tx_byte[0];
					end
					// odd parity then stop
					if (tx_state == 4'd9)
						ps2_kbd_data <= parity;
					if (tx_state == 4'd10)
						ps2_kbd_data <= 1'b1;
					tx_state <= (tx_state == 4'd11) ? 4'd0 : tx_state + 4'd1;
				end
			end
		end
	end

	// F0 marks a break, E0 an extended code
	assign pressed  = (key_raw[15:8] != 8'hf0);
	assign extended = pressed ? (key_raw[15:8] == 8'he0) : (key_raw[23:16] == 8'he0);

	always_ff @(posedge clk_sys or posedge CONF_DATA0) begin
		if (CONF_DATA0) begin
			key_raw <= '0;
			got_key <= 1'b0;
			ps2_key <= '0;
		end else if (frame_end && got_key) begin
			// bit 10 toggles for every event
			ps2_key <= {~ps2_key[10], pressed, extended, key_raw[7:0]};
			key_raw <= '0;
			got_key <= 1'b0;
		end else if (kbd_byte) begin
			key_raw <= {key_raw[23:0], byte_data};
			got_key <= 1'b1;
		end
	end

	// controller sent more than the FIFO can hold
	a_kbd_fifo_overflow: assert property (
		@(posedge clk_sys) disable iff (CONF_DATA0)
		kbd_byte |-> !fifo_full
	);

endmodule

/* logic/sector_loader.sv */
`timescale 1ns/1ns
// sd sector writer
// copies sector payload into the lower buffer half and holds sd_ack for the frame

module sector_loader #(
	parameter int BUF_AW = 10
) (
	input  logic              clk_sys,
	input  logic              CONF_DATA0,
	input  logic [7:0]        cmd,
	input  logic              byte_valid,
	input  logic [7:0]        byte_data,
	input  logic              frame_end,
	output logic              sd_ack,
	output logic              sec_wr,
	output logic [BUF_AW-1:0] sec_addr,
	output logic [7:0]        sec_data
);
	import io_link_pkg::*;

	localparam logic [BUF_AW-2:0] last_addr = (BUF_AW - 1)'(sector_bytes - 1);

	logic [BUF_AW-2:0] offset;

	always_ff @(posedge clk_sys or posedge CONF_DATA0) begin
		if (CONF_DATA0) begin
			sd_ack   <= 1'b0;
			sec_wr   <= 1'b0;
			sec_addr <= '0;
			sec_data <= '0;
			offset   <= '0;
		end else begin
			sec_wr <= 1'b0;
			if (frame_end) begin
				sd_ack <= 1'b0;
				offset <= '0;
			end else if (cmd == cmd_sector_wr) begin
				// cmd is valid from the end of byte 0
				sd_ack <= 1'b1;
				if (byte_valid) begin
					sec_wr   <= 1'b1;
					sec_addr <= {1'b0, offset};
					sec_data <= byte_data;
					// stays on the last byte of the sector
					if (offset != last_addr)
						offset <= offset + 1'b1;
				end
			end
		end
	end

endmodule

/* logic/file_loader.sv */
`timescale 1ns/1ns
// file download
// start and end of a download, menu file index and write pulses
// into the upper half of the shared buffer

module file_loader #(
	parameter int BUF_AW = 10
) (
	input  logic              clk_sys,
	input  logic              CONF_DATA0,
	input  logic [7:0]        cmd,
	input  logic              byte_valid,
	input  logic [7:0]        byte_data,
	output logic              ioctl_download,
	output logic [7:0]        ioctl_index,
	output logic              file_wr,
	output logic [BUF_AW-1:0] file_addr,
	output logic [7:0]        file_data
);
	import io_link_pkg::*;

	// offset within the file region, wraps
	logic [BUF_AW-2:0] offset;

	always_ff @(posedge clk_sys or posedge CONF_DATA0) begin
		if (CONF_DATA0) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			file_wr        <= 1'b0;
			file_addr      <= '0;
			file_data      <= '0;
			offset         <= '0;
		end else begin
			file_wr <= 1'b0;
			if (byte_valid) begin
				case (cmd)
					// nonzero starts, zero ends
					cmd_file_tx: begin
						ioctl_download <= (byte_data != 8'h00);
						if (byte_data != 8'h00)
							offset <= '0;
					end
					cmd_file_data: if (ioctl_download) begin
						file_wr   <= 1'b1;
						file_addr <= {1'b1, offset};
						file_data <= byte_data;
						offset    <= offset + 1'b1;
					end
					cmd_file_index:
						ioctl_index <= byte_data;
					default: ;
				endcase
			end
		end
	end

endmodule

/* logic/buffer_arbiter.sv */
`timescale 1ns/1ns
// shared buffer and arbiter
// single-port byte RAM, sector writes first, then file writes,
// then the pending core read

module buffer_arbiter #(
	parameter int BUF_AW = 10
) (
	input  logic              clk_sys,
	input  logic              CONF_DATA0,
	input  logic              sec_wr,
	input  logic [BUF_AW-1:0] sec_addr,
	input  logic [7:0]        sec_data,
	input  logic              file_wr,
	input  logic [BUF_AW-1:0] file_addr,
	input  logic [7:0]        file_data,
	input  logic              core_rd,
	input  logic [BUF_AW-1:0] core_addr,
	output logic              core_rd_valid,
	output logic [7:0]        core_rd_data
);

	logic [7:0]        mem [2**BUF_AW];
	// core read waiting for a free cycle
	logic              pending;
	logic [BUF_AW-1:0] pend_addr;
	logic              any_wr;

	assign any_wr = sec_wr | file_wr;

	// one access per cycle on the single port
	always_ff @(posedge clk_sys) begin
		if (sec_wr)
			mem[sec_addr] <= sec_data;
		else if (file_wr)
			mem[file_addr] <= file_data;
		else if (pending)
			core_rd_data <= mem[pend_addr];
	end

	always_ff @(posedge clk_sys or posedge CONF_DATA0) begin
		if (CONF_DATA0) begin
			pending       <= 1'b0;
			pend_addr     <= '0;
			core_rd_valid <= 1'b0;
		end else begin
			// read data lands with this pulse
			core_rd_valid <= pending & ~any_wr;
			if (core_rd) begin
				pending   <= 1'b1;
				pend_addr <= core_addr;
			end else if (!any_wr) begin
				pending <= 1'b0;
			end
		end
	end

	// only one writer is active per frame
	a_writer_collision: assert property (
		@(posedge clk_sys) disable iff (CONF_DATA0)
		!(sec_wr && file_wr)
	);

endmodule

/* logic/io_bridge_top.sv */
`timescale 1ns/1ns
// io bridge top level
// spi link from the menu controller, configuration registers, ps/2 keyboard,
// sector and file writers sharing one buffer with the core read port

module io_bridge_top #(
	parameter int BUF_AW = 10,
	parameter int PS2DIV = 100
) (
	input  logic              clk_sys,
	input  logic              CONF_DATA0,
	input  logic              spi_sck,
	input  logic              spi_di,
	input  logic              spi_sel,
	output logic              spi_do,
	output logic [1:0]        buttons,
	output logic [1:0]        switches,
	output logic [7:0]        joystick_0,
	output logic [7:0]        joystick_1,
	output logic [31:0]       status,
	output logic [1:0]        img_mounted,
	output logic [31:0]       img_size,
	output logic              ps2_kbd_clk,
	output logic              ps2_kbd_data,
	output logic [10:0]       ps2_key,
	output logic              sd_ack,
	output logic              ioctl_download,
	output logic [7:0]        ioctl_index,
	input  logic              core_rd,
	input  logic [BUF_AW-1:0] core_addr,
	output logic              core_rd_valid,
	output logic [7:0]        core_rd_data
);
	import io_link_pkg::*;

	// link to peers
	logic [7:0]            cmd;
	logic                  byte_valid;
	logic [7:0]            byte_data;
	logic [byte_idx_w-1:0] byte_idx;
	logic                  frame_end;
	// buffer writers
	logic                  sec_wr;
	logic [BUF_AW-1:0]     sec_addr;
	logic [7:0]            sec_data;
	logic                  file_wr;
	logic [BUF_AW-1:0]     file_addr;
	logic [7:0]            file_data;

	spi_link i_spi_link (
		.clk_sys, .CONF_DATA0, .spi_sck, .spi_di, .spi_sel, .spi_do,
		.cmd, .byte_valid, .byte_data, .byte_idx, .frame_end
	);

	cmd_regs i_cmd_regs (
		.clk_sys, .CONF_DATA0, .cmd, .byte_valid, .byte_data, .byte_idx,
		.buttons, .switches, .joystick_0, .joystick_1, .status,
		.img_mounted, .img_size
	);

	ps2_kbd_tx #(.PS2DIV(PS2DIV)) i_ps2_kbd_tx (
		.clk_sys, .CONF_DATA0, .cmd, .byte_valid, .byte_data, .frame_end,
		.ps2_kbd_clk, .ps2_kbd_data, .ps2_key
	);

	sector_loader #(.BUF_AW(BUF_AW)) i_sector_loader (
		.clk_sys, .CONF_DATA0, .cmd, .byte_valid, .byte_data, .frame_end,
		.sd_ack, .sec_wr, .sec_addr, .sec_data
	);

	file_loader #(.BUF_AW(BUF_AW)) i_file_loader (
		.clk_sys, .CONF_DATA0, .cmd, .byte_valid, .byte_data,
		.ioctl_download, .ioctl_index, .file_wr, .file_addr, .file_data
	);

	buffer_arbiter #(.BUF_AW(BUF_AW)) i_buffer_arbiter (
		.clk_sys, .CONF_DATA0,
		.sec_wr, .sec_addr, .sec_data,
		.file_wr, .file_addr, .file_data,
		.core_rd, .core_addr, .core_rd_valid, .core_rd_data
	);

endmodule

/* verification/tb_spi_tasks.svh */
// spi link and ps/2 helpers for the io bridge testbench
// drive frames as the menu controller, capture keyboard frames, read the buffer

`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp) begin
		$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		err_cnt++;
	end
endtask

// select the fpga, give the synchronizer time
task automatic frame_begin();
	spi_sel = 1'b1;
	repeat (4) @(negedge clk_sys);
endtask

// one byte MSB first, spi_do captured just before each rising sck
task automatic spi_byte(input logic [7:0] b, output logic [7:0] rb);
	for (int i = 7; i >= 0; i--) begin
		spi_sck = 1'b0;
		spi_di  = b[i];
		repeat (4) @(negedge clk_sys);
		rb[i]   = spi_do;
		spi_sck = 1'b1;
		repeat (4) @(negedge clk_sys);
	end
endtask

// last falling sck, then deselect and let frame_end settle
task automatic frame_close();
	spi_sck = 1'b0;
	repeat (4) @(negedge clk_sys);
	spi_sel = 1'b0;
	repeat (8) @(negedge clk_sys);
endtask

task automatic send_frame(input logic [7:0] c, input byte_q_t payload, output logic [7:0] rb0);
	logic [7:0] rb;
	frame_begin();
	spi_byte(c, rb0);
	foreach (payload[i])
		spi_byte(payload[i], rb);
	frame_close();
endtask

// one falling edge of ps2_kbd_clk, seen from the falling clk_sys edge
task automatic wait_ps2_fall(output logic ok);
	int   n;
	logic prev;
	ok   = 1'b0;
	n    = 0;
	prev = ps2_kbd_clk;
	while (!ok && n < 1000) begin
		@(negedge clk_sys);
		if (prev && !ps2_kbd_clk)
			ok = 1'b1;
		prev = ps2_kbd_clk;
		n++;
	end
endtask

// bit 0 start, 8:1 data, 9 parity, 10 stop
task automatic capture_ps2_byte(output logic [10:0] bits);
	logic ok;
	bits = '0;
	for (int i = 0; i < 11; i++) begin
		wait_ps2_fall(ok);
		if (!ok) begin
			$display("timeout waiting for a falling ps2_kbd_clk edge, bit %0d", i);
			timeout_cnt++;
			return;
		end
		bits[i] = ps2_kbd_data;
	end
endtask

task automatic read_buffer(input logic [9:0] addr, output logic [7:0] data);
	int n;
	n         = 0;
	core_rd   = 1'b1;
	core_addr = addr;
	@(negedge clk_sys);
	core_rd   = 1'b0;
	while (!core_rd_valid && n < 50) begin
		@(negedge clk_sys);
		n++;
	end
	if (!core_rd_valid) begin
		$display("timeout waiting for core_rd_valid, address %h", addr);
		timeout_cnt++;
	end
	data = core_rd_data;
	@(negedge clk_sys);
endtask

`endif

/* verification/io_bridge_tb.sv */
`timescale 1ns/1ns
// io bridge testbench
// directed spi frames checking registers, readback, sector writes,
// file download and the ps/2 keyboard output

module io_bridge_tb;

	typedef logic [7:0] byte_q_t [$];

	logic        clk_sys;
	logic        CONF_DATA0;
	logic        spi_sck;
	logic        spi_di;
	logic        spi_sel;
	logic        spi_do;
	logic [1:0]  buttons;
	logic [1:0]  switches;
	logic [7:0]  joystick_0;
	logic [7:0]  joystick_1;
	logic [31:0] status;
	logic [1:0]  img_mounted;
	logic [31:0] img_size;
	logic        ps2_kbd_clk;
	logic        ps2_kbd_data;
	logic [10:0] ps2_key;
	logic        sd_ack;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic        core_rd;
	logic [9:0]  core_addr;
	logic        core_rd_valid;
	logic [7:0]  core_rd_data;
	int          err_cnt;
	int          timeout_cnt;
	// mount pulses seen since the last clear
	logic        mount_clr;
	logic [1:0]  mount_seen;

	io_bridge_top #(.BUF_AW(10), .PS2DIV(4)) i_dut (.*);

	`include "tb_spi_tasks.svh"

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys)
		mount_seen <= mount_clr ? 2'b00 : (mount_seen | img_mounted);

	function automatic logic [7:0] rnd_byte();
		logic [31:0] r;
		r = $urandom;
		return r[7:0];
	endfunction

	task automatic config_registers();
		byte_q_t     q;
		logic [7:0]  rb;
		logic [7:0]  b_btn;
		logic [7:0]  b_j0;
		logic [7:0]  b_j1;
		logic [7:0]  b_s8;
		logic [31:0] s32;
		b_btn = rnd_byte();
		b_j0  = rnd_byte();
		b_j1  = rnd_byte();
		b_s8  = rnd_byte();
		s32   = {rnd_byte(), rnd_byte(), rnd_byte(), rnd_byte()};
		q = '{b_btn};
		send_frame(8'h01, q, rb);
		q = '{b_j0};
		send_frame(8'h02, q, rb);
		q = '{b_j1};
		send_frame(8'h03, q, rb);
		// low byte first
		q = '{s32[7:0], s32[15:8], s32[23:16], s32[31:24]};
		send_frame(8'h1e, q, rb);
		check("status", status, s32);
		q = '{b_s8};
		send_frame(8'h15, q, rb);
		check("buttons", 32'(buttons), 32'(b_btn[1:0]));
		check("switches", 32'(switches), 32'(b_btn[3:2]));
		check("joystick_0", 32'(joystick_0), 32'(b_j0));
		check("joystick_1", 32'(joystick_1), 32'(b_j1));
		// upper 24 bits untouched by the 8 bit form
		check("status", status, {s32[31:8], b_s8});
	endtask

	task automatic readback_and_mount();
		byte_q_t     q;
		logic [7:0]  rb;
		logic [31:0] size;
		mount_clr = 1'b1;
		@(negedge clk_sys);
		mount_clr = 1'b0;
		q = '{8'h01};
		send_frame(8'h1c, q, rb);
		check("spi_do readback", 32'(rb), 32'h000000a4);
		check("img_mounted", 32'(mount_seen), 32'h2);
		check("img_mounted idle", 32'(img_mounted), 32'h0);
		size = {rnd_byte(), rnd_byte(), rnd_byte(), rnd_byte()};
		q = '{size[7:0], size[15:8], size[23:16], size[31:24]};
		send_frame(8'h1d, q, rb);
		check("img_size", img_size, size);
	endtask

	task automatic sector_write();
		logic [7:0] data [16];
		logic [7:0] rb;
		logic [7:0] d;
		frame_begin();
		spi_byte(8'h17, rb);
		check("sd_ack after command", 32'(sd_ack), 32'h1);
		for (int i = 0; i < 16; i++) begin
			data[i] = rnd_byte();
			spi_byte(data[i], rb);
		end
		check("sd_ack in frame", 32'(sd_ack), 32'h1);
		frame_close();
		check("sd_ack after frame", 32'(sd_ack), 32'h0);
		for (int i = 0; i < 16; i++) begin
			read_buffer(10'(i), d);
			check("sector data", 32'(d), 32'(data[i]));
		end
	endtask

	task automatic file_download();
		byte_q_t    q;
		logic [7:0] pre [16];
		logic [7:0] a [8];
		logic [7:0] rb;
		logic [7:0] idx;
		logic [7:0] d;
		q = '{8'h01};
		send_frame(8'h53, q, rb);
		check("ioctl_download", 32'(ioctl_download), 32'h1);
		idx = rnd_byte();
		q = '{idx};
		send_frame(8'h55, q, rb);
		check("ioctl_index", 32'(ioctl_index), 32'(idx));
		// fill 512..527 so that later stray writes would show
		q.delete();
		for (int i = 0; i < 16; i++) begin
			pre[i] = rnd_byte();
			q.push_back(pre[i]);
		end
		send_frame(8'h54, q, rb);
		// restart, offset back to 512
		q = '{8'h01};
		send_frame(8'h53, q, rb);
		q.delete();
		for (int i = 0; i < 8; i++) begin
			a[i] = rnd_byte();
			q.push_back(a[i]);
		end
		send_frame(8'h54, q, rb);
		q = '{8'h00};
		send_frame(8'h53, q, rb);
		check("ioctl_download", 32'(ioctl_download), 32'h0);
		// not downloading, must be dropped
		q.delete();
		for (int i = 0; i < 8; i++)
			q.push_back(~pre[8 + i]);
		send_frame(8'h54, q, rb);
		for (int i = 0; i < 16; i++) begin
			read_buffer(10'd512 + 10'(i), d);
			check("file data", 32'(d), 32'((i < 8) ? a[i] : pre[i]));
		end
	endtask

	task automatic keyboard_frames();
		byte_q_t     q;
		logic [7:0]  exp [3];
		logic [10:0] bits [3];
		logic [10:0] old_key;
		logic [7:0]  rb;
		// extended break of 0x74
		exp = '{8'he0, 8'hf0, 8'h74};
		q   = '{8'he0, 8'hf0, 8'h74};
		old_key = ps2_key;
		fork
			send_frame(8'h05, q, rb);
			begin
				for (int k = 0; k < 3; k++)
					capture_ps2_byte(bits[k]);
			end
		join
		for (int k = 0; k < 3; k++) begin
			check("ps2 start bit", 32'(bits[k][0]), 32'h0);
			check("ps2 data", 32'(bits[k][8:1]), 32'(exp[k]));
			check("ps2 odd parity", 32'(^bits[k][9:1]), 32'h1);
			check("ps2 stop bit", 32'(bits[k][10]), 32'h1);
		end
		check("ps2_key", 32'(ps2_key), 32'({~old_key[10], 1'b0, 1'b1, 8'h74}));
	endtask

	initial begin
		CONF_DATA0  = 1'b1;
		spi_sck     = 1'b0;
		spi_di      = 1'b0;
		spi_sel     = 1'b0;
		core_rd     = 1'b0;
		core_addr   = '0;
		mount_clr   = 1'b1;
		err_cnt     = 0;
		timeout_cnt = 0;
		void'($urandom(32'h5101d08b));
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		CONF_DATA0 = 1'b0;
		mount_clr  = 1'b0;
		repeat (2) @(negedge clk_sys);
		check("sd_ack", 32'(sd_ack), 32'h0);
		check("ioctl_download", 32'(ioctl_download), 32'h0);
		check("ps2_kbd_clk", 32'(ps2_kbd_clk), 32'h1);
		check("ps2_kbd_data", 32'(ps2_kbd_data), 32'h1);
		check("ps2_key", 32'(ps2_key), 32'h0);
		config_registers();
		readback_and_mount();
		sector_write();
		file_download();
		keyboard_frames();
		$display("errors: %0d check failures, %0d timeouts", err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+verification
logic/io_link_pkg.sv
logic/spi_link.sv
logic/cmd_regs.sv
logic/ps2_kbd_tx.sv
logic/sector_loader.sv
logic/file_loader.sv
logic/buffer_arbiter.sv
logic/io_bridge_top.sv
verification/io_bridge_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the io bridge testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module io_bridge_tb -o sim_io_bridge

out=$(./obj_dir/sim_io_bridge)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "test passed"; then
	exit 0
fi
exit 1
